//--- hdl/riscv_isa_pkg.sv
package riscv_isa_pkg;

  localparam int unsigned XLEN = 32;

  typedef logic [4:0] reg_addr_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Major opcodes handled by the core
  localparam opcode_t OP_REG   = 7'b0110011;
  localparam opcode_t OP_IMM   = 7'b0010011;
  localparam opcode_t OP_LUI   = 7'b0110111;
  localparam opcode_t OP_LOAD  = 7'b0000011;
  localparam opcode_t OP_STORE = 7'b0100011;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SR      = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;
  localparam funct3_t F3_LW_SW   = 3'b010;

  // funct7[5] set means SUB / SRA
  localparam logic F7_ALT = 1'b1;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

  // ---------------------------------------------------------------------------
  // Instruction formats
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    funct3_t    funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    funct3_t     funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    funct3_t    funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    opcode_t     opcode;
  } u_fmt_t;

  // One fetched word, viewed per format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } instr_u;

endpackage

//--- hdl/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

  import riscv_isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  // Decoded control, all zero for a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    use_imm;
    alu_op_e alu_op;
  } ctrl_t;

  // ---------------------------------------------------------------------------
  // Pipeline registers
  // ---------------------------------------------------------------------------
  typedef struct packed {
    ctrl_t            ctrl;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    reg_addr_t        rd;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;
    logic [XLEN-1:0]  imm;
  } id_ex_t;

  typedef struct packed {
    logic             reg_write;
    logic             mem_read;
    reg_addr_t        rd;
    logic [XLEN-1:0]  alu_result;
  } ex_mem_t;

  typedef struct packed {
    logic             reg_write;
    reg_addr_t        rd;
    logic [XLEN-1:0]  wdata;
  } mem_wb_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  riscv_isa_pkg::reg_addr_t         rs1_i,
  input  riscv_isa_pkg::reg_addr_t         rs2_i,
  input  cpu_pipe_pkg::mem_wb_t            wb_i,
  output logic [riscv_isa_pkg::XLEN-1:0]   rs1_data_o,
  output logic [riscv_isa_pkg::XLEN-1:0]   rs2_data_o
);
  import riscv_isa_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.reg_write && wb_i.rd != '0) begin
      regs_q[wb_i.rd] <= wb_i.wdata;
    end
  end

  // Write-through so a write and read in one cycle returns the new value
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (wb_i.reg_write && wb_i.rd == rs1_i) begin
      rs1_data_o = wb_i.wdata;
    end else begin
      rs1_data_o = regs_q[rs1_i];
    end
  end

  always_comb begin
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else if (wb_i.reg_write && wb_i.rd == rs2_i) begin
      rs2_data_o = wb_i.wdata;
    end else begin
      rs2_data_o = regs_q[rs2_i];
    end
  end

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int unsigned IM_ADDR_W = 14
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            stall_i,
  output logic [IM_ADDR_W-1:0]            im_addr_o,
  input  logic [riscv_isa_pkg::XLEN-1:0]  im_data_i,
  output riscv_isa_pkg::instr_u           instr_o
);
  import riscv_isa_pkg::*;

  // Word address, one instruction per step
  logic [IM_ADDR_W-1:0] pc_q;
  instr_u               instr_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else if (!stall_i) begin
      pc_q <= pc_q + IM_ADDR_W'(1);
    end
  end

  // IF/ID register, frozen on a load-use stall
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_q <= INSTR_NOP;
    end else if (!stall_i) begin
      instr_q <= im_data_i;
    end
  end

  assign im_addr_o = pc_q;
  assign instr_o   = instr_q;

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            stall_i,
  input  riscv_isa_pkg::instr_u           instr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]  rs1_data_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]  rs2_data_i,
  output riscv_isa_pkg::reg_addr_t        rs1_o,
  output riscv_isa_pkg::reg_addr_t        rs2_o,
  output cpu_pipe_pkg::id_ex_t            id_ex_o
);
  import riscv_isa_pkg::*;
  import cpu_pipe_pkg::*;

  ctrl_t           ctrl_d, ctrl_q;
  reg_addr_t       rs1_d, rs2_d;
  logic [XLEN-1:0] imm_d;
  reg_addr_t       rs1_q, rs2_q, rd_q;
  logic [XLEN-1:0] rs1_data_q, rs2_data_q, imm_q;

  // Immediate forms only allow SRAI as the alternate op
  function automatic alu_op_e alu_sel(funct3_t f3, logic alt, logic is_reg);
    case (f3)
      F3_ADD_SUB: return (is_reg && alt == F7_ALT) ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SR:      return (alt == F7_ALT) ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      F3_AND:     return ALU_AND;
      default:    return ALU_ADD;
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // Decode by opcode, unknown words fall through as no-ops
  // ---------------------------------------------------------------------------
  always_comb begin
    ctrl_d = '0;
    imm_d  = '0;
    rs1_d  = '0;
    rs2_d  = '0;
    case (instr_i.r.opcode)
      OP_REG: begin
        ctrl_d.reg_write = 1'b1;
        ctrl_d.alu_op    = alu_sel(instr_i.r.funct3, instr_i.r.funct7[5], 1'b1);
        rs1_d            = instr_i.r.rs1;
        rs2_d            = instr_i.r.rs2;
      end
      OP_IMM: begin
        ctrl_d.reg_write = 1'b1;
        ctrl_d.use_imm   = 1'b1;
        ctrl_d.alu_op    = alu_sel(instr_i.i.funct3, instr_i.r.funct7[5], 1'b0);
        rs1_d            = instr_i.i.rs1;
        imm_d            = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
      end
      OP_LUI: begin
        ctrl_d.reg_write = 1'b1;
        ctrl_d.use_imm   = 1'b1;
        ctrl_d.alu_op    = ALU_PASS_B;
        imm_d            = {instr_i.u.imm, 12'b0};
      end
      OP_LOAD: begin
        if (instr_i.i.funct3 == F3_LW_SW) begin
          ctrl_d.reg_write = 1'b1;
          ctrl_d.mem_read  = 1'b1;
          ctrl_d.use_imm   = 1'b1;
          ctrl_d.alu_op    = ALU_ADD;
          rs1_d            = instr_i.i.rs1;
          imm_d            = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
        end
      end
      OP_STORE: begin
        if (instr_i.s.funct3 == F3_LW_SW) begin
          ctrl_d.mem_write = 1'b1;
          ctrl_d.use_imm   = 1'b1;
          ctrl_d.alu_op    = ALU_ADD;
          rs1_d            = instr_i.s.rs1;
          rs2_d            = instr_i.s.rs2;
          imm_d = {{(XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
        end
      end
      default: begin
      end
    endcase
  end

  assign rs1_o = rs1_d;
  assign rs2_o = rs2_d;

  // ID/EX control, a bubble on stall
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else if (stall_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rs1_q      <= rs1_d;
    rs2_q      <= rs2_d;
    rd_q       <= instr_i.r.rd;
    rs1_data_q <= rs1_data_i;
    rs2_data_q <= rs2_data_i;
    imm_q      <= imm_d;
  end

  assign id_ex_o = '{ctrl: ctrl_q, rs1: rs1_q, rs2: rs2_q, rd: rd_q,
                     rs1_data: rs1_data_q, rs2_data: rs2_data_q, imm: imm_q};

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  riscv_isa_pkg::reg_addr_t  rs1_i,
  input  riscv_isa_pkg::reg_addr_t  rs2_i,
  input  cpu_pipe_pkg::id_ex_t      id_ex_i,
  input  cpu_pipe_pkg::ex_mem_t     ex_mem_i,
  input  cpu_pipe_pkg::mem_wb_t     wb_i,
  output logic                      stall_o,
  output cpu_pipe_pkg::fwd_sel_e    fwd_a_o,
  output cpu_pipe_pkg::fwd_sel_e    fwd_b_o
);
  import riscv_isa_pkg::*;
  import cpu_pipe_pkg::*;

  // Younger result wins, so MEM is checked first
  function automatic fwd_sel_e fwd_pick(reg_addr_t src, ex_mem_t mem, mem_wb_t wb);
    if (src == '0) begin
      return FWD_NONE;
    end
    if (mem.reg_write && mem.rd == src) begin
      return FWD_MEM;
    end
    if (wb.reg_write && wb.rd == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  assign fwd_a_o = fwd_pick(id_ex_i.rs1, ex_mem_i, wb_i);
  assign fwd_b_o = fwd_pick(id_ex_i.rs2, ex_mem_i, wb_i);

  // Load data is not ready until MEM, hold decode one cycle
  assign stall_o = id_ex_i.ctrl.mem_read && (id_ex_i.rd != '0) &&
                   (id_ex_i.rd == rs1_i || id_ex_i.rd == rs2_i);

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
  parameter int unsigned DM_ADDR_W = 14
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  cpu_pipe_pkg::id_ex_t            id_ex_i,
  input  cpu_pipe_pkg::fwd_sel_e          fwd_a_i,
  input  cpu_pipe_pkg::fwd_sel_e          fwd_b_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]  mem_fwd_i,
  input  cpu_pipe_pkg::mem_wb_t           wb_i,
  output logic [DM_ADDR_W-1:0]            dm_addr_o,
  output logic                            dm_we_o,
  output logic                            dm_oe_o,
  output logic [riscv_isa_pkg::XLEN-1:0]  dm_wdata_o,
  output cpu_pipe_pkg::ex_mem_t           ex_mem_o
);
  import riscv_isa_pkg::*;
  import cpu_pipe_pkg::*;

  logic [XLEN-1:0] op_a, rs2_fwd, op_b, alu_res;
  logic [4:0]      shamt;
  logic            reg_write_q, mem_read_q;
  reg_addr_t       rd_q;
  logic [XLEN-1:0] result_q;

  // ---------------------------------------------------------------------------
  // Operand forwarding
  // ---------------------------------------------------------------------------
  always_comb begin
    case (fwd_a_i)
      FWD_MEM: op_a = mem_fwd_i;
      FWD_WB:  op_a = wb_i.wdata;
      default: op_a = id_ex_i.rs1_data;
    endcase
    case (fwd_b_i)
      FWD_MEM: rs2_fwd = mem_fwd_i;
      FWD_WB:  rs2_fwd = wb_i.wdata;
      default: rs2_fwd = id_ex_i.rs2_data;
    endcase
  end

  assign op_b  = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;
  assign shamt = op_b[4:0];

  always_comb begin
    case (id_ex_i.ctrl.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_res = XLEN'(op_a < op_b);
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // SRAM request in the execute cycle, byte offset dropped
  assign dm_addr_o  = alu_res[DM_ADDR_W+1:2];
  assign dm_we_o    = id_ex_i.ctrl.mem_write;
  assign dm_oe_o    = id_ex_i.ctrl.mem_read;
  assign dm_wdata_o = rs2_fwd;

  // EX/MEM register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_write_q <= 1'b0;
      mem_read_q  <= 1'b0;
    end else begin
      reg_write_q <= id_ex_i.ctrl.reg_write;
      mem_read_q  <= id_ex_i.ctrl.mem_read;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q     <= id_ex_i.rd;
    result_q <= alu_res;
  end

  assign ex_mem_o = '{reg_write: reg_write_q, mem_read: mem_read_q, rd: rd_q,
                      alu_result: result_q};

endmodule

//--- hdl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  cpu_pipe_pkg::ex_mem_t           ex_mem_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]  dm_rdata_i,
  output logic [riscv_isa_pkg::XLEN-1:0]  mem_fwd_o,
  output cpu_pipe_pkg::mem_wb_t           wb_o
);
  import riscv_isa_pkg::*;

  logic [XLEN-1:0] mem_val;
  logic            reg_write_q;
  reg_addr_t       rd_q;
  logic [XLEN-1:0] wdata_q;

  // SRAM data is valid for the whole memory cycle
  assign mem_val   = ex_mem_i.mem_read ? dm_rdata_i : ex_mem_i.alu_result;
  assign mem_fwd_o = mem_val;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_write_q <= 1'b0;
    end else begin
      reg_write_q <= ex_mem_i.reg_write;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q    <= ex_mem_i.rd;
    wdata_q <= mem_val;
  end

  assign wb_o = '{reg_write: reg_write_q, rd: rd_q, wdata: wdata_q};

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
  parameter int unsigned IM_ADDR_W = 14,
  parameter int unsigned DM_ADDR_W = 14
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  output logic [IM_ADDR_W-1:0]            im_addr_o,
  input  logic [riscv_isa_pkg::XLEN-1:0]  im_data_i,
  output logic [DM_ADDR_W-1:0]            dm_addr_o,
  output logic                            dm_we_o,
  output logic                            dm_oe_o,
  output logic [riscv_isa_pkg::XLEN-1:0]  dm_wdata_o,
  input  logic [riscv_isa_pkg::XLEN-1:0]  dm_rdata_i
);
  import riscv_isa_pkg::*;
  import cpu_pipe_pkg::*;

  instr_u          instr_id;
  reg_addr_t       rs1_id, rs2_id;
  logic [XLEN-1:0] rs1_data_id, rs2_data_id;
  logic [XLEN-1:0] mem_fwd;
  id_ex_t          id_ex;
  ex_mem_t         ex_mem;
  mem_wb_t         mem_wb;
  logic            stall;
  fwd_sel_e        fwd_a, fwd_b;

  // ---------------------------------------------------------------------------
  // Front end
  // ---------------------------------------------------------------------------
  fetch_stage #(.IM_ADDR_W(IM_ADDR_W)) u_fetch (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .stall_i   (stall),
    .im_addr_o (im_addr_o),
    .im_data_i (im_data_i),
    .instr_o   (instr_id)
  );

  decode_stage u_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall),
    .instr_i    (instr_id),
    .rs1_data_i (rs1_data_id),
    .rs2_data_i (rs2_data_id),
    .rs1_o      (rs1_id),
    .rs2_o      (rs2_id),
    .id_ex_o    (id_ex)
  );

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_i      (rs1_id),
    .rs2_i      (rs2_id),
    .wb_i       (mem_wb),
    .rs1_data_o (rs1_data_id),
    .rs2_data_o (rs2_data_id)
  );

  hazard_unit u_hazard (
    .rs1_i    (rs1_id),
    .rs2_i    (rs2_id),
    .id_ex_i  (id_ex),
    .ex_mem_i (ex_mem),
    .wb_i     (mem_wb),
    .stall_o  (stall),
    .fwd_a_o  (fwd_a),
    .fwd_b_o  (fwd_b)
  );

  // ---------------------------------------------------------------------------
  // Back end
  // ---------------------------------------------------------------------------
  execute_stage #(.DM_ADDR_W(DM_ADDR_W)) u_execute (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .id_ex_i    (id_ex),
    .fwd_a_i    (fwd_a),
    .fwd_b_i    (fwd_b),
    .mem_fwd_i  (mem_fwd),
    .wb_i       (mem_wb),
    .dm_addr_o  (dm_addr_o),
    .dm_we_o    (dm_we_o),
    .dm_oe_o    (dm_oe_o),
    .dm_wdata_o (dm_wdata_o),
    .ex_mem_o   (ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ex_mem_i   (ex_mem),
    .dm_rdata_i (dm_rdata_i),
    .mem_fwd_o  (mem_fwd),
    .wb_o       (mem_wb)
  );

endmodule

//--- testbench/cpu_core_sva.sv
`timescale 1ns/1ps

module cpu_core_sva #(
  parameter int unsigned IM_ADDR_W = 14
) (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic [IM_ADDR_W-1:0] im_addr_o,
  input logic                 dm_we_o,
  input logic                 dm_oe_o
);

  // Data memory is either read or written, never both
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(dm_we_o && dm_oe_o))
    else $error("dm_we_o and dm_oe_o high together");

  assert property (@(posedge clk_i) !rst_n_i |-> (!dm_we_o && !dm_oe_o))
    else $error("Data memory request during reset");

  // No branches, so the PC only advances or holds on a stall
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   $past(rst_n_i) |-> (im_addr_o == $past(im_addr_o) ||
                   im_addr_o == IM_ADDR_W'($past(im_addr_o) + 1'b1)))
    else $error("im_addr_o jumped by more than one word");

endmodule

bind cpu_core cpu_core_sva #(.IM_ADDR_W(IM_ADDR_W)) u_sva (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .im_addr_o (im_addr_o),
  .dm_we_o   (dm_we_o),
  .dm_oe_o   (dm_oe_o)
);

//--- testbench/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

  localparam int unsigned IM_ADDR_W  = 8;
  localparam int unsigned DM_ADDR_W  = 8;
  localparam int unsigned CLK_PERIOD = 40;
  localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

  logic                 clk_i = 1'b0;
  logic                 rst_n_i;
  logic [IM_ADDR_W-1:0] im_addr_o;
  logic [31:0]          im_data_i;
  logic [DM_ADDR_W-1:0] dm_addr_o;
  logic                 dm_we_o;
  logic                 dm_oe_o;
  logic [31:0]          dm_wdata_o;
  logic [31:0]          dm_rdata_i;

  // Program and expected-store tables
  logic [31:0]          prog_q[$];
  logic [DM_ADDR_W-1:0] exp_addr_q[$];
  logic [31:0]          exp_data_q[$];

  logic [31:0]          imem [0:(1<<IM_ADDR_W)-1];
  logic [31:0]          dmem [0:(1<<DM_ADDR_W)-1];
  logic [31:0]          rd_word;
  logic                 req_we, req_oe;
  logic [DM_ADDR_W-1:0] req_addr;
  logic [31:0]          req_wdata;

  int err_cnt   = 0;
  int check_cnt = 0;
  int store_cnt = 0;

  cpu_core #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W)) dut_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .im_addr_o  (im_addr_o),
    .im_data_i  (im_data_i),
    .dm_addr_o  (dm_addr_o),
    .dm_we_o    (dm_we_o),
    .dm_oe_o    (dm_oe_o),
    .dm_wdata_o (dm_wdata_o),
    .dm_rdata_i (dm_rdata_i)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------------------------------
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sw_instr(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] lui_instr(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] alu_imm(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
    return i_type(imm, rs1, f3, rd, 7'b0010011);
  endfunction

  // Store of rs2 to word k and the value it must carry
  task automatic add_store(logic [4:0] rs2, logic [DM_ADDR_W-1:0] k, logic [31:0] value);
    prog_q.push_back(sw_instr(12'(k) << 2, rs2, 5'd0));
    exp_addr_q.push_back(k);
    exp_data_q.push_back(value);
  endtask

  task automatic build_tables();
    // x1 = -7, x2 = 5, x3 = 0x12345000
    prog_q.push_back(alu_imm(12'hFF9, 5'd0, 3'b000, 5'd1));
    prog_q.push_back(alu_imm(12'h005, 5'd0, 3'b000, 5'd2));
    prog_q.push_back(lui_instr(20'h12345, 5'd3));
    // Distances 2 and 3 on the sources, 1 on the store data
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
    add_store(5'd4, 0, 32'hFFFF_FFFE);
    prog_q.push_back(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd5));
    add_store(5'd5, 1, 32'h0000_000C);
    prog_q.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd6));
    add_store(5'd6, 2, 32'hFFFF_FFFF);
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd7));
    add_store(5'd7, 3, 32'h07FF_FFFF);
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd2, 3'b001, 5'd8));
    add_store(5'd8, 4, 32'h0000_00A0);
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd9));
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd10));
    add_store(5'd9, 5, 32'h0000_0001);
    add_store(5'd10, 6, 32'h0000_0000);
    prog_q.push_back(r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd11));
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd12));
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd3, 3'b100, 5'd13));
    add_store(5'd11, 7, 32'h1234_5000);
    add_store(5'd12, 8, 32'hFFFF_FFFD);
    add_store(5'd13, 9, 32'h1234_5005);
    add_store(5'd3, 10, 32'h1234_5000);
    // Immediate group
    prog_q.push_back(alu_imm(12'h0F0, 5'd1, 3'b111, 5'd14));
    prog_q.push_back(alu_imm(12'hF00, 5'd2, 3'b110, 5'd15));
    prog_q.push_back(alu_imm(12'hFFF, 5'd1, 3'b100, 5'd16));
    prog_q.push_back(alu_imm(12'hFFA, 5'd1, 3'b010, 5'd17));
    prog_q.push_back(alu_imm(12'hFFF, 5'd2, 3'b011, 5'd18));
    prog_q.push_back(alu_imm(12'h01C, 5'd2, 3'b001, 5'd19));
    prog_q.push_back(alu_imm(12'h01C, 5'd1, 3'b101, 5'd20));
    prog_q.push_back(alu_imm(12'h401, 5'd1, 3'b101, 5'd21));
    add_store(5'd14, 11, 32'h0000_00F0);
    add_store(5'd15, 12, 32'hFFFF_FF05);
    add_store(5'd16, 13, 32'h0000_0006);
    add_store(5'd17, 14, 32'h0000_0001);
    add_store(5'd18, 15, 32'h0000_0001);
    add_store(5'd19, 16, 32'h5000_0000);
    add_store(5'd20, 17, 32'h0000_000F);
    add_store(5'd21, 18, 32'hFFFF_FFFC);
    // Load followed at once by a user of the loaded value
    add_store(5'd1, 19, 32'hFFFF_FFF9);
    prog_q.push_back(i_type(12'd76, 5'd0, 3'b010, 5'd22, 7'b0000011));
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd22, 3'b000, 5'd23));
    add_store(5'd23, 20, 32'hFFFF_FFFE);
    // x0 stays zero
    prog_q.push_back(alu_imm(12'd99, 5'd0, 3'b000, 5'd0));
    add_store(5'd0, 21, 32'h0000_0000);
    // Distance 1 between two ALU ops
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd2, 3'b000, 5'd24));
    prog_q.push_back(r_type(7'h00, 5'd2, 5'd24, 3'b000, 5'd25));
    add_store(5'd25, 22, 32'h0000_000F);
  endtask

  // --------------------------------------------------------------------------
  // Memory models
  // --------------------------------------------------------------------------
  always begin
    @(negedge clk_i);
    im_data_i  <= imem[im_addr_o];
    dm_rdata_i <= rd_word;
    #5;
    req_we    = dm_we_o;
    req_oe    = dm_oe_o;
    req_addr  = dm_addr_o;
    req_wdata = dm_wdata_o;
  end

  always @(posedge clk_i) begin
    if (req_we) begin
      dmem[req_addr] <= req_wdata;
    end
    if (req_oe) begin
      rd_word <= dmem[req_addr];
    end
  end

  task automatic check_idle(string when);
    check_cnt++;
    if (dm_we_o || dm_oe_o || im_addr_o != '0) begin
      err_cnt++;
      $display("[FAIL] %0t ns: %s, we=%b oe=%b pc=%0d", $time, when,
               dm_we_o, dm_oe_o, im_addr_o);
    end
  endtask

  // Watchdog
  initial begin
    #1;
    #((prog_q.size() + 30) * CLK_PERIOD);
    $display("Timeout: only %0d of %0d expected stores arrived", store_cnt, exp_addr_q.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rst_n_i    = 1'b0;
    im_data_i  = NOP_WORD;
    dm_rdata_i = '0;
    rd_word    = '0;
    req_we     = 1'b0;
    req_oe     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    build_tables();
    for (int i = 0; i < (1 << IM_ADDR_W); i++) begin
      imem[i] = (i < prog_q.size()) ? prog_q[i] : NOP_WORD;
    end
    for (int i = 0; i < (1 << DM_ADDR_W); i++) begin
      dmem[i] = 32'(i) * 32'h9E37_79B9 ^ 32'hA5A5_0000;
    end

    repeat (2) begin
      @(negedge clk_i);
      check_idle("busy during reset");
    end
    rst_n_i = 1'b1;
    #1;
    check_idle("busy in first cycle after reset");

    // Stores in program order
    for (int k = 0; k < exp_addr_q.size(); k++) begin
      do begin
        @(negedge clk_i);
        #5;
      end while (!dm_we_o);
      store_cnt++;
      check_cnt++;
      if (dm_addr_o != exp_addr_q[k]) begin
        err_cnt++;
        $display("[FAIL] %0t ns: store %0d addr %0d, expected %0d", $time, k,
                 dm_addr_o, exp_addr_q[k]);
      end
      check_cnt++;
      if (dm_wdata_o != exp_data_q[k]) begin
        err_cnt++;
        $display("[FAIL] %0t ns: store %0d data %h, expected %h", $time, k,
                 dm_wdata_o, exp_data_q[k]);
      end
    end

    // Nothing but no-ops after the last store
    repeat (10) begin
      @(negedge clk_i);
      #5;
      if (dm_we_o) begin
        err_cnt++;
        $display("Unexpected store to word %0d after the last expected store", dm_addr_o);
      end
    end

    $display("Checks: %0d, stores: %0d, errors: %0d", check_cnt, store_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
hdl/riscv_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu_core.sv
testbench/cpu_core_sva.sv
testbench/tb_cpu_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_cpu_core
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

output=$(./obj_dir/Vtb_cpu_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
